// ==== logic/marsPkg.sv ====
package marsPkg;

	// bus widths
	localparam int DATA_W = 16;
	localparam int SH_ADDR_W = 21;	// sh2 word address, bits 21..1
	localparam int MD_ADDR_W = 24;
	localparam int COMM_COUNT = 8;

	typedef logic [DATA_W-1:0] dataT;
	typedef logic [SH_ADDR_W:1] shAddrT;
	typedef logic [MD_ADDR_W-1:0] mdAddrT;
	typedef logic [$clog2(COMM_COUNT)-1:0] commIdxT;
	typedef logic [3:0] irqVecT;	// one bit per interrupt source
	typedef logic [3:0] irlT;

	// sh2 side byte addresses, cs0 space
	localparam logic [SH_ADDR_W:0] SYS_BASE = 22'h004000;	// 0x4000..0x401F
	localparam logic [SH_ADDR_W:0] COMM_BASE = 22'h004020;	// 0x4020..0x402F

	// 68k side map
	localparam mdAddrT MD_COMM_BASE = 24'hA15120;
	localparam mdAddrT MD_ID_ADDR = 24'hA130EC;
	localparam mdAddrT MD_ADAPTER_ADDR = 24'hA15100;
	localparam mdAddrT MD_INTC_ADDR = 24'hA15102;

	localparam dataT ADAPTER_VALUE = 16'h0181;
	localparam dataT ID_HIGH = 16'h4D41;	// "MA"
	localparam dataT ID_LOW = 16'h5253;	// "RS"

	// FM=1, ADEN=1, all enables off
	localparam dataT INT_CONT_RESET = 16'h8200;

	// bit positions inside irqVecT
	localparam int IRQ_VRES = 3;
	localparam int IRQ_VINT = 2;
	localparam int IRQ_HINT = 1;
	localparam int IRQ_CMD = 0;

	// interrupt levels as seen by the sh2
	localparam irlT IRL_VRES = 4'd14;
	localparam irlT IRL_VINT = 4'd12;
	localparam irlT IRL_HINT = 4'd10;
	localparam irlT IRL_CMD = 4'd8;
	localparam irlT IRL_IDLE = 4'd0;

	typedef enum logic [1:0] {
		regNone,
		regSys,	// 0x4000 block
		regComm	// comm words
	} regionT;

	// word offsets inside the system block
	typedef enum logic [3:0] {
		rgIntCont = 4'd0,
		rgVresClr = 4'd10,
		rgVintClr = 4'd11,
		rgHintClr = 4'd12,
		rgCintClr = 4'd13
	} sysRegT;

endpackage

// ==== logic/sh2BusCtrl.sv ====
`timescale 1ns/1ps

module sh2BusCtrl (
	input logic CLOCK,
	input logic RESET_N,
	input marsPkg::shAddrT shAddr,
	input logic shBsN,
	input logic shRdN,
	input logic shCs0MN,
	input logic shCs0SN,
	input logic shDqmHN,
	input logic shDqmLN,
	input marsPkg::dataT sysRdData,
	input marsPkg::dataT commRdData,
	inout wire marsPkg::dataT shData,
	output marsPkg::regionT region,
	output logic [3:0] wordIdx,
	output logic shWr,
	output logic cpuSlave,
	output logic laneHi,
	output logic laneLo,
	output marsPkg::dataT wrData
);

	import marsPkg::*;

	logic bsPrev;	// bus strobe seen last cycle
	logic csAny;
	logic sysHit;
	logic commHit;
	logic rdEn;
	logic [SH_ADDR_W:0] byteAddr;
	dataT rdData;

	// end of bus cycle is the rising edge of bs
	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			bsPrev <= 1'b1;	// idle bus, no edge straight out of reset
		end else begin
			bsPrev <= shBsN;
		end
	end

	assign csAny = !shCs0MN || !shCs0SN;
	assign byteAddr = {shAddr, 1'b0};

	// 32 byte system block, 16 byte comm block
	assign sysHit = byteAddr[SH_ADDR_W:5] == SYS_BASE[SH_ADDR_W:5];
	assign commHit = byteAddr[SH_ADDR_W:4] == COMM_BASE[SH_ADDR_W:4];

	always_comb begin
		region = regNone;
		if (csAny) begin
			if (sysHit)
				region = regSys;
			else if (commHit)
				region = regComm;
		end
	end

	assign wordIdx = shAddr[4:1];	// comm uses the low three
	assign shWr = !bsPrev && shBsN && shRdN;	// write only, one cycle
	assign cpuSlave = !shCs0SN;
	assign laneHi = !shDqmHN;	// dqm active low
	assign laneLo = !shDqmLN;
	assign wrData = shData;

	// read path
	assign rdData = (region == regSys) ? sysRdData : commRdData;
	assign rdEn = csAny && !shRdN && (region != regNone);

	// release the bus when nobody of ours is addressed
	assign shData = rdEn ? rdData : 'z;

endmodule

// ==== logic/sysRegFile.sv ====
`timescale 1ns/1ps

module sysRegFile (
	input logic CLOCK,
	input logic RESET_N,
	input marsPkg::regionT region,
	input logic [3:0] wordIdx,
	input logic shWr,
	input logic cpuSlave,
	input logic laneHi,
	input logic laneLo,
	input marsPkg::dataT wrData,
	output marsPkg::dataT sysRdData,
	output marsPkg::irqVecT enMaster,
	output marsPkg::irqVecT enSlave,
	output marsPkg::irqVecT clrMaster,
	output marsPkg::irqVecT clrSlave
);

	import marsPkg::*;

	logic [15:4] intShared;	// FM, ADEN, CART, HEN ... shared by both cpus
	logic [3:0] nibMaster;	// V H CMD PWM
	logic [3:0] nibSlave;
	logic sysWr;
	logic ctlWr;
	irqVecT clrVec;

	assign sysWr = shWr && (region == regSys);
	assign ctlWr = sysWr && (wordIdx == rgIntCont);

	// clear words are pure actions
	always_comb begin
		clrVec = '0;
		if (sysWr) begin
			case (sysRegT'(wordIdx))
				rgVresClr: clrVec[IRQ_VRES] = 1'b1;
				rgVintClr: clrVec[IRQ_VINT] = 1'b1;
				rgHintClr: clrVec[IRQ_HINT] = 1'b1;
				rgCintClr: clrVec[IRQ_CMD] = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			intShared <= INT_CONT_RESET[15:4];
			nibMaster <= 4'h0;
			nibSlave <= 4'h0;
			clrMaster <= '0;
			clrSlave <= '0;
		end else begin
			clrMaster <= cpuSlave ? '0 : clrVec;	// pulse goes to the writer only
			clrSlave <= cpuSlave ? clrVec : '0;
			if (ctlWr) begin
				if (laneHi)
					intShared[15:8] <= wrData[15:8];
				if (laneLo) begin
					intShared[7:4] <= wrData[7:4];
					// each cpu owns its own nibble
					if (cpuSlave)
						nibSlave <= wrData[3:0];
					else
						nibMaster <= wrData[3:0];
				end
			end
		end
	end

	// vres has no mask bit, always allowed
	assign enMaster = {1'b1, nibMaster[3:1]};
	assign enSlave = {1'b1, nibSlave[3:1]};

	always_comb begin
		sysRdData = '0;	// clear words read back 0
		if (region == regSys && wordIdx == rgIntCont)
			sysRdData = {intShared, cpuSlave ? nibSlave : nibMaster};
	end

endmodule

// ==== logic/commRegFile.sv ====
`timescale 1ns/1ps

module commRegFile (
	input logic CLOCK,
	input logic RESET_N,
	input marsPkg::regionT region,
	input logic [3:0] wordIdx,
	input logic shWr,
	input logic laneHi,
	input logic laneLo,
	input marsPkg::dataT wrData,
	input logic mdCommWr,
	input marsPkg::commIdxT mdCommIdx,
	input logic mdLaneHi,
	input logic mdLaneLo,
	input marsPkg::dataT mdWrData,
	output marsPkg::dataT commRdData,
	output marsPkg::dataT commAll [marsPkg::COMM_COUNT]
);

	import marsPkg::*;

	commIdxT shIdx;
	logic shCommWr;

	assign shIdx = wordIdx[$bits(commIdxT)-1:0];	// 0x4020 + 2*idx
	assign shCommWr = shWr && (region == regComm);

	// 68k beats sh2 per byte lane when both hit the same word
	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			for (int i = 0; i < COMM_COUNT; i++)
				commAll[i] <= '0;
		end else begin
			for (int i = 0; i < COMM_COUNT; i++) begin
				// upper byte
				if (mdCommWr && mdCommIdx == i && mdLaneHi)
					commAll[i][15:8] <= mdWrData[15:8];
				else if (shCommWr && shIdx == i && laneHi)
					commAll[i][15:8] <= wrData[15:8];
				// lower byte
				if (mdCommWr && mdCommIdx == i && mdLaneLo)
					commAll[i][7:0] <= mdWrData[7:0];
				else if (shCommWr && shIdx == i && laneLo)
					commAll[i][7:0] <= wrData[7:0];
			end
		end
	end

	assign commRdData = commAll[shIdx];	// sh2 read side

endmodule

// ==== logic/irqGen.sv ====
`timescale 1ns/1ps

module irqGen (
	input logic CLOCK,
	input logic RESET_N,
	input logic vsync,
	input logic hsync,
	input logic vresReq,
	input logic [1:0] cmdReq,	// bit 0 master, bit 1 slave
	input marsPkg::irqVecT enMaster,
	input marsPkg::irqVecT enSlave,
	input marsPkg::irqVecT clrMaster,
	input marsPkg::irqVecT clrSlave,
	output logic [2:0] irlMasterN,
	output logic [2:0] irlSlaveN
);

	import marsPkg::*;

	logic vsyncPrev;
	logic hsyncPrev;
	logic vFall;
	logic hFall;
	irqVecT enVec [2];	// index 0 master, 1 slave
	irqVecT clrVec [2];
	irqVecT setVec [2];
	irqVecT trig [2];
	irlT irlM;
	irlT irlS;

	// highest source wins
	function automatic irlT irlOf(input irqVecT t);
		irlT lvl;
		if (t[IRQ_VRES])
			lvl = IRL_VRES;
		else if (t[IRQ_VINT])
			lvl = IRL_VINT;
		else if (t[IRQ_HINT])
			lvl = IRL_HINT;
		else if (t[IRQ_CMD])
			lvl = IRL_CMD;
		else
			lvl = IRL_IDLE;
		return lvl;
	endfunction

	assign vFall = vsyncPrev && !vsync;
	assign hFall = hsyncPrev && !hsync;
	assign enVec[0] = enMaster;
	assign enVec[1] = enSlave;
	assign clrVec[0] = clrMaster;
	assign clrVec[1] = clrSlave;

	always_comb begin
		for (int c = 0; c < 2; c++) begin
			setVec[c][IRQ_VRES] = vresReq;
			setVec[c][IRQ_VINT] = vFall && enVec[c][IRQ_VINT];
			setVec[c][IRQ_HINT] = hFall && enVec[c][IRQ_HINT];
			setVec[c][IRQ_CMD] = cmdReq[c] && enVec[c][IRQ_CMD];
		end
	end

	always_ff @(posedge CLOCK or negedge RESET_N) begin
		if (!RESET_N) begin
			vsyncPrev <= 1'b0;	// no edge until sync has been seen high
			hsyncPrev <= 1'b0;
			trig[0] <= '0;
			trig[1] <= '0;
		end else begin
			vsyncPrev <= vsync;
			hsyncPrev <= hsync;
			// vres is never held and only lives as long as its level
			for (int c = 0; c < 2; c++)
				trig[c] <= setVec[c] | (trig[c] & ~clrVec[c] & ~irqVecT'(1 << IRQ_VRES));	// set beats clear
		end
	end

	assign irlM = irlOf(trig[0]);
	assign irlS = irlOf(trig[1]);

	// irl0 comes from FT0A on the board so only 3..1 are ours
	assign irlMasterN = ~irlM[3:1];
	assign irlSlaveN = ~irlS[3:1];

endmodule

// ==== logic/mdBusPort.sv ====
`timescale 1ns/1ps

module mdBusPort (
	input marsPkg::mdAddrT mdAddr,
	input logic mdAsN,
	input logic mdRnw,
	input logic mdUdsN,
	input logic mdLdsN,
	input marsPkg::dataT mdWrData,
	input marsPkg::dataT commAll [marsPkg::COMM_COUNT],
	output marsPkg::dataT mdRdData,
	output logic mdCommWr,
	output marsPkg::commIdxT mdCommIdx,
	output logic mdLaneHi,
	output logic mdLaneLo,
	output logic [1:0] cmdReq
);

	import marsPkg::*;

	logic mdWr;
	logic idHit;
	logic adapterHit;
	logic intcHit;
	logic commHit;

	// address decode, 68k byte addresses
	assign idHit = mdAddr[MD_ADDR_W-1:2] == MD_ID_ADDR[MD_ADDR_W-1:2];	// 4 bytes
	assign adapterHit = mdAddr[MD_ADDR_W-1:1] == MD_ADAPTER_ADDR[MD_ADDR_W-1:1];
	assign intcHit = mdAddr[MD_ADDR_W-1:1] == MD_INTC_ADDR[MD_ADDR_W-1:1];
	assign commHit = mdAddr[MD_ADDR_W-1:4] == MD_COMM_BASE[MD_ADDR_W-1:4];	// 16 bytes

	assign mdWr = !mdAsN && !mdRnw;	// level, every cycle as is low
	assign mdLaneHi = !mdUdsN;
	assign mdLaneLo = !mdLdsN;
	assign mdCommIdx = mdAddr[3:1];
	assign mdCommWr = mdWr && commHit;

	// INTM / INTS sit in the low byte
	assign cmdReq = (mdWr && intcHit && mdLaneLo) ? mdWrData[1:0] : 2'b00;

	assign mdRdData = (idHit && !mdAddr[1]) ? ID_HIGH :
		(idHit && mdAddr[1]) ? ID_LOW :
		adapterHit ? ADAPTER_VALUE :
		commHit ? commAll[mdCommIdx] :
		16'hFFFF;	// open bus

endmodule

// ==== logic/marsSysCore.sv ====
`timescale 1ns/1ps

module marsSysCore (
	input logic CLOCK,
	input logic RESET_N,

	// sh2 bus, shared by master and slave
	input marsPkg::shAddrT shAddr,
	inout wire marsPkg::dataT shData,
	input logic shBsN,
	input logic shRdN,
	input logic shCs0MN,
	input logic shCs0SN,
	input logic shDqmHN,
	input logic shDqmLN,

	// video timing and reset request
	input logic vsync,
	input logic hsync,
	input logic vresReq,

	output logic [2:0] irlMasterN,
	output logic [2:0] irlSlaveN,

	// 68k side
	input marsPkg::mdAddrT mdAddr,
	input logic mdAsN,
	input logic mdRnw,
	input logic mdUdsN,
	input logic mdLdsN,
	input marsPkg::dataT mdWrData,
	output marsPkg::dataT mdRdData
);

	import marsPkg::*;

	regionT region;
	logic [3:0] wordIdx;
	logic shWr;
	logic cpuSlave;
	logic laneHi;
	logic laneLo;
	dataT wrData;
	dataT sysRdData;
	dataT commRdData;
	dataT commAll [COMM_COUNT];
	irqVecT enMaster;
	irqVecT enSlave;
	irqVecT clrMaster;
	irqVecT clrSlave;
	logic mdCommWr;
	commIdxT mdCommIdx;
	logic mdLaneHi;
	logic mdLaneLo;
	logic [1:0] cmdReq;

	sh2BusCtrl u_sh2BusCtrl (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.shAddr(shAddr), .shBsN(shBsN), .shRdN(shRdN),
		.shCs0MN(shCs0MN), .shCs0SN(shCs0SN),
		.shDqmHN(shDqmHN), .shDqmLN(shDqmLN),
		.sysRdData(sysRdData), .commRdData(commRdData),
		.shData(shData),
		.region(region), .wordIdx(wordIdx), .shWr(shWr), .cpuSlave(cpuSlave),
		.laneHi(laneHi), .laneLo(laneLo), .wrData(wrData)
	);

	sysRegFile u_sysRegFile (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.region(region), .wordIdx(wordIdx), .shWr(shWr), .cpuSlave(cpuSlave),
		.laneHi(laneHi), .laneLo(laneLo), .wrData(wrData),
		.sysRdData(sysRdData),
		.enMaster(enMaster), .enSlave(enSlave),
		.clrMaster(clrMaster), .clrSlave(clrSlave)
	);

	commRegFile u_commRegFile (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.region(region), .wordIdx(wordIdx), .shWr(shWr),
		.laneHi(laneHi), .laneLo(laneLo), .wrData(wrData),
		.mdCommWr(mdCommWr), .mdCommIdx(mdCommIdx),
		.mdLaneHi(mdLaneHi), .mdLaneLo(mdLaneLo), .mdWrData(mdWrData),
		.commRdData(commRdData), .commAll(commAll)
	);

	irqGen u_irqGen (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.vsync(vsync), .hsync(hsync), .vresReq(vresReq), .cmdReq(cmdReq),
		.enMaster(enMaster), .enSlave(enSlave),
		.clrMaster(clrMaster), .clrSlave(clrSlave),
		.irlMasterN(irlMasterN), .irlSlaveN(irlSlaveN)
	);

	mdBusPort u_mdBusPort (
		.mdAddr(mdAddr), .mdAsN(mdAsN), .mdRnw(mdRnw),
		.mdUdsN(mdUdsN), .mdLdsN(mdLdsN), .mdWrData(mdWrData),
		.commAll(commAll),
		.mdRdData(mdRdData), .mdCommWr(mdCommWr), .mdCommIdx(mdCommIdx),
		.mdLaneHi(mdLaneHi), .mdLaneLo(mdLaneLo), .cmdReq(cmdReq)
	);

endmodule

// ==== verif/marsSysCoreTb.sv ====
`timescale 1ns/1ps

module marsSysCoreTb;

	import marsPkg::*;

	typedef enum logic [2:0] {
		opShWr,
		opShRd,
		opMdWr,
		opMdRd,
		opVsync,
		opHsync,
		opVres,
		opIrl
	} opT;

	typedef struct packed {
		opT op;
		logic cpu;	// 0 master, 1 slave
		mdAddrT addr;	// byte address on either bus
		dataT data;
		logic [1:0] lanes;	// {hi, lo}
		dataT expVal;
	} rowT;

	logic CLOCK;
	logic RESET_N;
	shAddrT shAddr;
	wire dataT shData;
	dataT shOut;	// sh2 write data
	logic shDrive;
	logic shBsN;
	logic shRdN;
	logic shCs0MN;
	logic shCs0SN;
	logic shDqmHN;
	logic shDqmLN;
	logic vsync;
	logic hsync;
	logic vresReq;
	logic [2:0] irlMasterN;
	logic [2:0] irlSlaveN;
	mdAddrT mdAddr;
	logic mdAsN;
	logic mdRnw;
	logic mdUdsN;
	logic mdLdsN;
	dataT mdWrData;
	dataT mdRdData;

	rowT rows[$];
	string names[$];
	dataT commModel [8];	// expected comm contents
	int errors;
	int checks;
	int cycles;
	int cycleLimit;

	marsSysCore u_marsSysCore (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.shAddr(shAddr), .shData(shData), .shBsN(shBsN), .shRdN(shRdN),
		.shCs0MN(shCs0MN), .shCs0SN(shCs0SN), .shDqmHN(shDqmHN), .shDqmLN(shDqmLN),
		.vsync(vsync), .hsync(hsync), .vresReq(vresReq),
		.irlMasterN(irlMasterN), .irlSlaveN(irlSlaveN),
		.mdAddr(mdAddr), .mdAsN(mdAsN), .mdRnw(mdRnw), .mdUdsN(mdUdsN),
		.mdLdsN(mdLdsN), .mdWrData(mdWrData), .mdRdData(mdRdData)
	);

	assign shData = shDrive ? shOut : 'z;

	initial begin
		CLOCK = 1'b0;
		forever #4 CLOCK = ~CLOCK;	// 8 ns
	end

	always @(posedge CLOCK) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("run stopped, cycle limit of %0d reached", cycleLimit);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic addRow(input string name, input opT op, input logic cpu,
		input mdAddrT addr, input dataT data, input logic [1:0] lanes, input dataT expVal);
		rowT r;
		r.op = op;
		r.cpu = cpu;
		r.addr = addr;
		r.data = data;
		r.lanes = lanes;
		r.expVal = expVal;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic shIdle;
		shCs0MN = 1'b1;
		shCs0SN = 1'b1;
		shDqmHN = 1'b1;
		shDqmLN = 1'b1;
		shRdN = 1'b1;
		shBsN = 1'b1;
		shDrive = 1'b0;
	endtask

	task automatic shStart(input logic cpu, input mdAddrT addr, input logic rd);
		@(posedge CLOCK);
		#1;
		shAddr = addr[21:1];
		shCs0MN = cpu;
		shCs0SN = !cpu;
		shRdN = !rd;
		shBsN = 1'b0;
	endtask

	task automatic shWrite(input logic cpu, input mdAddrT addr, input dataT data,
		input logic [1:0] lanes);
		shStart(cpu, addr, 1'b0);
		shDqmHN = !lanes[1];
		shDqmLN = !lanes[0];
		shOut = data;
		shDrive = 1'b1;
		@(posedge CLOCK);
		#1;
		shBsN = 1'b1;	// strobe cycle
		@(posedge CLOCK);
		#1;
		shIdle;
	endtask

	task automatic shRead(input logic cpu, input mdAddrT addr, output dataT val);
		shStart(cpu, addr, 1'b1);
		#3 val = shData;
		@(posedge CLOCK);
		#1;
		shBsN = 1'b1;	// rd still low, no write edge
		@(posedge CLOCK);
		#1;
		shIdle;
	endtask

	task automatic mdAccess(input mdAddrT addr, input dataT data, input logic [1:0] lanes,
		input logic rd, output dataT val);
		@(posedge CLOCK);
		#1;
		mdAddr = addr;
		mdWrData = data;
		mdRnw = rd;
		mdUdsN = !lanes[1];
		mdLdsN = !lanes[0];
		mdAsN = 1'b0;
		#3 val = mdRdData;
		@(posedge CLOCK);
		#1;
		mdAsN = 1'b1;	// single write cycle
		mdRnw = 1'b1;
		mdUdsN = 1'b1;
		mdLdsN = 1'b1;
	endtask

	// byte-lane merge into the expected comm word
	task automatic mergeLanes(input logic [2:0] idx, input dataT data, input logic [1:0] lanes);
		if (lanes[1])
			commModel[idx][15:8] = data[15:8];
		if (lanes[0])
			commModel[idx][7:0] = data[7:0];
	endtask

	function automatic irlT pinsToIrl(input logic [2:0] pins);
		return {~pins, 1'b0};	// pins carry level bits 3..1 inverted
	endfunction

	task automatic checkData(input string name, input dataT expVal, input dataT actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("ERROR %s expected %h actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkIrl(input string name, input irlT expVal, input irlT actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("ERROR %s expected %0d actual %0d", name, expVal, actVal);
		end
	endtask

	task automatic applyRow(input rowT r, input string name);
		dataT got;
		dataT expVal;
		logic shSide;
		logic isComm;
		shSide = (r.op == opShWr) || (r.op == opShRd);
		isComm = shSide ? (r.addr[23:4] == 20'h00402) : (r.addr[23:4] == 20'hA1512);
		expVal = isComm ? commModel[r.addr[3:1]] : r.expVal;	// comm words follow the model
		case (r.op)
			opShWr: begin
				shWrite(r.cpu, r.addr, r.data, r.lanes);
				if (isComm)
					mergeLanes(r.addr[3:1], r.data, r.lanes);
			end
			opMdWr: begin
				mdAccess(r.addr, r.data, r.lanes, 1'b0, got);
				if (isComm)
					mergeLanes(r.addr[3:1], r.data, r.lanes);
			end
			opShRd: begin
				shRead(r.cpu, r.addr, got);
				checkData(name, expVal, got);
			end
			opMdRd: begin
				mdAccess(r.addr, 16'h0000, 2'b11, 1'b1, got);
				checkData(name, expVal, got);
			end
			opVsync, opHsync: begin
				@(posedge CLOCK);
				#1;
				if (r.op == opVsync)
					vsync = 1'b1;
				else
					hsync = 1'b1;
				@(posedge CLOCK);
				#1;
				vsync = 1'b0;	// falling edge here
				hsync = 1'b0;
			end
			opVres: begin
				@(posedge CLOCK);
				#1 vresReq = r.data[0];
			end
			default: begin
				repeat (2) @(posedge CLOCK);	// irl settles within 2 cycles
				#2;
				checkIrl(name, r.expVal[3:0], pinsToIrl(r.cpu ? irlSlaveN : irlMasterN));
			end
		endcase
	endtask

	initial begin
		errors = 0;
		checks = 0;
		cycles = 0;
		cycleLimit = 100000;
		RESET_N = 1'b0;
		shAddr = '0;
		shOut = '0;
		shIdle;
		vsync = 1'b0;
		hsync = 1'b0;
		vresReq = 1'b0;
		mdAddr = '0;
		mdAsN = 1'b1;
		mdRnw = 1'b1;
		mdUdsN = 1'b1;
		mdLdsN = 1'b1;
		mdWrData = '0;
		for (int i = 0; i < 8; i++)
			commModel[i] = '0;
		void'($urandom(32'h9fb7_df35));

		// reset state
		addRow("intCont reset master", opShRd, 1'b0, 24'h004000, 16'h0, 2'b11, 16'h8200);
		addRow("intCont reset slave", opShRd, 1'b1, 24'h004000, 16'h0, 2'b11, 16'h8200);
		for (int i = 0; i < 8; i++) begin
			addRow($sformatf("comm reset sh %0d", i), opShRd, i[0],
				mdAddrT'(24'h004020 + 2 * i), 16'h0, 2'b11, 16'h0);
			addRow($sformatf("comm reset md %0d", i), opMdRd, 1'b0,
				mdAddrT'(24'hA15120 + 2 * i), 16'h0, 2'b11, 16'h0);
		end
		addRow("irl reset master", opIrl, 1'b0, 24'h0, 16'h0, 2'b00, 16'd0);
		addRow("irl reset slave", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd0);

		// sh2 writes, full word then one lane
		for (int i = 0; i < 8; i++) begin
			addRow($sformatf("comm sh full %0d", i), opShWr, i[1],
				mdAddrT'(24'h004020 + 2 * i), dataT'($urandom), 2'b11, 16'h0);
			addRow($sformatf("comm sh lane %0d", i), opShWr, i[1],
				mdAddrT'(24'h004020 + 2 * i), dataT'($urandom), i[0] ? 2'b10 : 2'b01, 16'h0);
			addRow($sformatf("comm sh read %0d", i), opShRd, i[0],
				mdAddrT'(24'h004020 + 2 * i), 16'h0, 2'b11, 16'h0);
			addRow($sformatf("comm md read %0d", i), opMdRd, 1'b0,
				mdAddrT'(24'hA15120 + 2 * i), 16'h0, 2'b11, 16'h0);
		end
		// 68k lane writes seen from the sh2
		for (int i = 0; i < 8; i++) begin
			addRow($sformatf("comm md lane %0d", i), opMdWr, 1'b0,
				mdAddrT'(24'hA15120 + 2 * i), dataT'($urandom), i[0] ? 2'b01 : 2'b10, 16'h0);
			addRow($sformatf("comm md to sh %0d", i), opShRd, !i[0],
				mdAddrT'(24'h004020 + 2 * i), 16'h0, 2'b11, 16'h0);
		end

		// 68k fixed words, "MA" "RS"
		addRow("id high", opMdRd, 1'b0, 24'hA130EC, 16'h0, 2'b11, 16'h4D41);
		addRow("id low", opMdRd, 1'b0, 24'hA130EE, 16'h0, 2'b11, 16'h5253);
		addRow("adapter", opMdRd, 1'b0, 24'hA15100, 16'h0, 2'b11, 16'h0181);
		addRow("unmapped", opMdRd, 1'b0, 24'hA15200, 16'h0, 2'b11, 16'hFFFF);

		// per-cpu nibbles, V for master and H for slave
		addRow("nib master write", opShWr, 1'b0, 24'h004000, 16'h0008, 2'b01, 16'h0);
		addRow("nib slave write", opShWr, 1'b1, 24'h004000, 16'h0004, 2'b01, 16'h0);
		addRow("nib master read", opShRd, 1'b0, 24'h004000, 16'h0, 2'b11, 16'h8208);
		addRow("nib slave read", opShRd, 1'b1, 24'h004000, 16'h0, 2'b11, 16'h8204);

		addRow("vsync", opVsync, 1'b0, 24'h0, 16'h0, 2'b00, 16'h0);
		addRow("vint master", opIrl, 1'b0, 24'h0, 16'h0, 2'b00, 16'd12);
		addRow("vint slave idle", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd0);
		addRow("hsync", opHsync, 1'b0, 24'h0, 16'h0, 2'b00, 16'h0);
		addRow("hint slave", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd10);
		addRow("vres on", opVres, 1'b0, 24'h0, 16'h1, 2'b00, 16'h0);
		addRow("vres master", opIrl, 1'b0, 24'h0, 16'h0, 2'b00, 16'd14);
		addRow("vres slave", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd14);
		addRow("vres off", opVres, 1'b0, 24'h0, 16'h0, 2'b00, 16'h0);
		addRow("vint back master", opIrl, 1'b0, 24'h0, 16'h0, 2'b00, 16'd12);
		addRow("vint clear", opShWr, 1'b0, 24'h004016, 16'h0, 2'b11, 16'h0);
		addRow("vint cleared", opIrl, 1'b0, 24'h0, 16'h0, 2'b00, 16'd0);
		addRow("hint still slave", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd10);

		// command interrupt to the slave only
		addRow("hint clear", opShWr, 1'b1, 24'h004018, 16'h0, 2'b11, 16'h0);
		addRow("hint cleared", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd0);
		addRow("cmd en master", opShWr, 1'b0, 24'h004000, 16'h0002, 2'b01, 16'h0);
		addRow("cmd en slave", opShWr, 1'b1, 24'h004000, 16'h0002, 2'b01, 16'h0);
		addRow("cmd request", opMdWr, 1'b0, 24'hA15102, 16'h0002, 2'b11, 16'h0);
		addRow("cmd slave", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd8);
		addRow("cmd master idle", opIrl, 1'b0, 24'h0, 16'h0, 2'b00, 16'd0);
		addRow("cint clear", opShWr, 1'b1, 24'h00401A, 16'h0, 2'b11, 16'h0);
		addRow("cint cleared", opIrl, 1'b1, 24'h0, 16'h0, 2'b00, 16'd0);

		cycleLimit = rows.size() * 40;

		repeat (8) @(posedge CLOCK);
		#1 RESET_N = 1'b1;

		for (int i = 0; i < rows.size(); i++)
			applyRow(rows[i], names[i]);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== marsSysCore.f ====
logic/marsPkg.sv
logic/sh2BusCtrl.sv
logic/sysRegFile.sv
logic/commRegFile.sv
logic/irqGen.sv
logic/mdBusPort.sv
logic/marsSysCore.sv
verif/marsSysCoreTb.sv
